/* include/cpu16_consts.svh */
`ifndef CPU16_CONSTS_SVH
`define CPU16_CONSTS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Data word width
`define CPU16_XLEN 16
// Register code width
`define CPU16_RAW 4
// Architectural registers r0 to r14
`define CPU16_NREGS 15
// Code 15 means operand comes from no register
`define CPU16_NO_REG 4'd15

// Data memory, 64 words
`define CPU16_DMEM_AW 6
`define CPU16_DMEM_DEPTH 64

//////////////////////////////
// Opcodes, instr[15:12]
//////////////////////////////

// Register-register forms
`define CPU16_OP_ADD 4'h0
`define CPU16_OP_SUB 4'h1
`define CPU16_OP_AND 4'h2
`define CPU16_OP_OR 4'h3
`define CPU16_OP_XOR 4'h4
`define CPU16_OP_SLL 4'h5
`define CPU16_OP_SRL 4'h6
// Immediate forms, imm4 zero-extended
`define CPU16_OP_ADDI 4'h7
`define CPU16_OP_LW 4'h8
`define CPU16_OP_SW 4'h9

`endif

/* logic/cpu16_pkg.sv */
`default_nettype none

`include "cpu16_consts.svh"

package cpu16_pkg;

	//////////////////////////////
	// Datapath vector types
	//////////////////////////////

	// One data word
	typedef logic [`CPU16_XLEN-1:0] word_t;

	// Register code, 15 is "no register"
	typedef logic [`CPU16_RAW-1:0] reg_addr_t;

	// Opcode, also used as ALU operation select
	typedef logic [3:0] alu_op_t;

	// Instruction word
	// op [15:12], rd [11:8], rs [7:4], rt or imm4 [3:0]
	typedef logic [15:0] instr_t;

	// Data memory word address
	// Low bits of the ALU result
	typedef logic [`CPU16_DMEM_AW-1:0] dmem_addr_t;

endpackage

`default_nettype wire

/* logic/cpu16_ex_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Decoded operation held in the ID/EX register
interface cpu16_ex_if;

	// ALU operation select
	cpu16_pkg::alu_op_t aluop;

	// Operand values as read in ID
	// alusrc2 already holds the immediate for immediate forms
	cpu16_pkg::word_t alusrc1;
	cpu16_pkg::word_t alusrc2;

	// Register codes behind the operands, NO_REG if none
	cpu16_pkg::reg_addr_t regsrc1;
	cpu16_pkg::reg_addr_t regsrc2;

	// Store data register and its value from the regfile
	cpu16_pkg::reg_addr_t regsrc_sw;
	cpu16_pkg::word_t memdata;

	// Pipeline register side
	modport stage_src (
		output aluop, alusrc1, alusrc2, regsrc1, regsrc2, regsrc_sw, memdata
	);

	// Execute stage side
	modport stage_dst (
		input aluop, alusrc1, alusrc2, regsrc1, regsrc2, regsrc_sw, memdata
	);

endinterface

`default_nettype wire

/* logic/cpu16_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu16_consts.svh"

module cpu16_decode (
	input  cpu16_pkg::instr_t    instr_i,
	output cpu16_pkg::reg_addr_t rd_o,
	output cpu16_pkg::reg_addr_t rs_o,
	output cpu16_pkg::reg_addr_t rt_o,
	output cpu16_pkg::alu_op_t   aluop_o,
	output cpu16_pkg::word_t     imm_o,
	output logic                 use_imm_o,
	output logic                 regwrite_o,
	output logic                 memread_o,
	output logic                 memwrite_o
);

	cpu16_pkg::alu_op_t op;
	logic is_alu_rr;

	// Field split
	assign op   = instr_i[15:12];
	assign rd_o = instr_i[11:8];
	assign rs_o = instr_i[7:4];

	// imm4, zero-extended
	assign imm_o = {{(`CPU16_XLEN-4){1'b0}}, instr_i[3:0]};

	// Register-register group
	assign is_alu_rr = (op == `CPU16_OP_ADD) || (op == `CPU16_OP_SUB) ||
			(op == `CPU16_OP_AND) || (op == `CPU16_OP_OR) ||
			(op == `CPU16_OP_XOR) || (op == `CPU16_OP_SLL) ||
			(op == `CPU16_OP_SRL);

	assign memread_o  = (op == `CPU16_OP_LW);
	assign memwrite_o = (op == `CPU16_OP_SW);
	assign use_imm_o  = (op == `CPU16_OP_ADDI) || memread_o || memwrite_o;

	// Immediate operand never matches a forwarding destination
	assign rt_o = use_imm_o ? `CPU16_NO_REG : instr_i[3:0];

	// Stores and NOPs write nothing, r15 is not a register
	assign regwrite_o = (is_alu_rr || (op == `CPU16_OP_ADDI) || memread_o) &&
			(rd_o != `CPU16_NO_REG);

	// Address computation for memory ops is a plain add
	assign aluop_o = (memread_o || memwrite_o) ? `CPU16_OP_ADD : op;

endmodule

`default_nettype wire

/* logic/cpu16_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu16_consts.svh"

module cpu16_regfile (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  cpu16_pkg::reg_addr_t ra1_i,
	input  cpu16_pkg::reg_addr_t ra2_i,
	input  cpu16_pkg::reg_addr_t ra3_i,
	input  cpu16_pkg::reg_addr_t wa_i,
	input  logic                 we_i,
	input  cpu16_pkg::word_t     wd_i,
	output cpu16_pkg::word_t     rd1_o,
	output cpu16_pkg::word_t     rd2_o,
	output cpu16_pkg::word_t     rd3_o
);

	// r0 to r14
	cpu16_pkg::word_t regs [`CPU16_NREGS];

	// One read port, code 15 reads zero
	// Write in the same cycle wins so WB is seen by ID
	function automatic cpu16_pkg::word_t read_port(input cpu16_pkg::reg_addr_t ra);
		cpu16_pkg::word_t val;
		if (ra == `CPU16_NO_REG)
			val = '0;
		else if (we_i && (ra == wa_i))
			val = wd_i;
		else
			val = regs[ra];
		return val;
	endfunction

	always_comb begin
		rd1_o = read_port(ra1_i);
		rd2_o = read_port(ra2_i);
		rd3_o = read_port(ra3_i);
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `CPU16_NREGS; i++)
				regs[i] <= '0;
		end else if (we_i && (wa_i != `CPU16_NO_REG)) begin
			regs[wa_i] <= wd_i;
		end
	end

endmodule

`default_nettype wire

/* logic/cpu16_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu16_consts.svh"

module cpu16_alu (
	input  cpu16_pkg::alu_op_t op_i,
	input  cpu16_pkg::word_t   a_i,
	input  cpu16_pkg::word_t   b_i,
	output cpu16_pkg::word_t   result_o
);

	// Shift amount, low four bits of b
	logic [3:0] shamt;

	assign shamt = b_i[3:0];

	always_comb begin
		case (op_i)
			`CPU16_OP_ADD:
				result_o = a_i + b_i;
			`CPU16_OP_SUB:
				result_o = a_i - b_i;
			`CPU16_OP_AND:
				result_o = a_i & b_i;
			`CPU16_OP_OR:
				result_o = a_i | b_i;
			`CPU16_OP_XOR:
				result_o = a_i ^ b_i;
			`CPU16_OP_SLL:
				result_o = a_i << shamt;
			`CPU16_OP_SRL:
				result_o = a_i >> shamt;
			// Immediate add and address generation
			`CPU16_OP_ADDI,
			`CPU16_OP_LW,
			`CPU16_OP_SW:
				result_o = a_i + b_i;
			// NOP
			default:
				result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* logic/cpu16_ex.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu16_ex (
	cpu16_ex_if.stage_dst        ex_if,
	input  cpu16_pkg::reg_addr_t exregdst_i,
	input  logic                 exregwrite_i,
	input  cpu16_pkg::word_t     exregdata_i,
	input  cpu16_pkg::reg_addr_t memregdst_i,
	input  logic                 memregwrite_i,
	input  cpu16_pkg::word_t     memregdata_i,
	output cpu16_pkg::word_t     alures_o,
	output cpu16_pkg::word_t     memdata_o
);

	//////////////////////////////
	// Forwarding
	//////////////////////////////

	cpu16_pkg::word_t opa;
	cpu16_pkg::word_t opb;

	// Freshest value of one source register
	// EX/MEM is younger than MEM/WB, so it is checked first
	// NO_REG never matches since no stage writes r15
	function automatic cpu16_pkg::word_t fwd_sel(
		input cpu16_pkg::reg_addr_t src,
		input cpu16_pkg::word_t     id_val
	);
		cpu16_pkg::word_t val;
		if (exregwrite_i && (exregdst_i == src))
			val = exregdata_i;
		else if (memregwrite_i && (memregdst_i == src))
			val = memregdata_i;
		else
			val = id_val;
		return val;
	endfunction

	always_comb begin
		opa = fwd_sel(ex_if.regsrc1, ex_if.alusrc1);
		// Immediate forms carry NO_REG here and keep imm4
		opb = fwd_sel(ex_if.regsrc2, ex_if.alusrc2);
		// Store data, same rule as the operands
		memdata_o = fwd_sel(ex_if.regsrc_sw, ex_if.memdata);
	end

	//////////////////////////////
	// ALU
	//////////////////////////////

	cpu16_alu u_alu (
		.op_i     (ex_if.aluop),
		.a_i      (opa),
		.b_i      (opb),
		.result_o (alures_o)
	);

endmodule

`default_nettype wire

/* logic/cpu16_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu16_consts.svh"

module cpu16_mem_stage (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  we_i,
	input  logic                  memread_i,
	input  cpu16_pkg::dmem_addr_t addr_i,
	input  cpu16_pkg::word_t      wdata_i,
	input  cpu16_pkg::word_t      alures_i,
	output cpu16_pkg::word_t      result_o
);

	// 64-word data memory
	cpu16_pkg::word_t mem [`CPU16_DMEM_DEPTH];
	cpu16_pkg::word_t rdata;

	// Read in the same cycle as the address
	assign rdata = mem[addr_i];

	// Write lands on the edge that leaves MEM
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			// Memory starts out all zero
			for (int i = 0; i < `CPU16_DMEM_DEPTH; i++)
				mem[i] <= '0;
		end else if (we_i) begin
			mem[addr_i] <= wdata_i;
		end
	end

	// Loads return the memory word, everything else the ALU result
	assign result_o = memread_i ? rdata : alures_i;

endmodule

`default_nettype wire

/* logic/cpu16_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu16_consts.svh"

module cpu16_core (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  instr_valid_i,
	input  cpu16_pkg::instr_t     instr_i,
	output logic                  wb_en_o,
	output cpu16_pkg::reg_addr_t  wb_dst_o,
	output cpu16_pkg::word_t      wb_data_o,
	output logic                  st_en_o,
	output cpu16_pkg::dmem_addr_t st_addr_o,
	output cpu16_pkg::word_t      st_data_o
);

	//////////////////////////////
	// Stage signals
	//////////////////////////////

	// IF/ID
	logic ifid_valid;
	cpu16_pkg::instr_t ifid_instr;

	// Decode outputs
	cpu16_pkg::reg_addr_t dec_rd, dec_rs, dec_rt;
	cpu16_pkg::alu_op_t dec_aluop;
	cpu16_pkg::word_t dec_imm;
	logic dec_use_imm, dec_regwrite, dec_memread, dec_memwrite;
	cpu16_pkg::word_t rf_rd1, rf_rd2, rf_rd3;

	// ID/EX
	// Payload lives in the interface
	logic idex_valid, idex_regwrite, idex_memread, idex_memwrite;
	cpu16_pkg::reg_addr_t idex_rd;
	cpu16_ex_if ex_bus ();
	cpu16_pkg::word_t ex_alures, ex_stdata;

	// EX/MEM
	logic exmem_valid, exmem_regwrite, exmem_memread, exmem_memwrite;
	cpu16_pkg::reg_addr_t exmem_rd;
	cpu16_pkg::word_t exmem_alures, exmem_stdata, mem_result;
	logic ex_fwd_we;

	// MEM/WB
	logic memwb_valid, memwb_regwrite;
	cpu16_pkg::reg_addr_t memwb_rd;
	cpu16_pkg::word_t memwb_data;
	logic wb_we;

	// Valid chain
	// A low instr_valid_i becomes a bubble
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ifid_valid  <= 1'b0;
			idex_valid  <= 1'b0;
			exmem_valid <= 1'b0;
			memwb_valid <= 1'b0;
		end else begin
			ifid_valid  <= instr_valid_i;
			idex_valid  <= ifid_valid;
			exmem_valid <= idex_valid;
			memwb_valid <= exmem_valid;
		end
	end

	//////////////////////////////
	// ID
	//////////////////////////////

	cpu16_decode u_decode (
		.instr_i (ifid_instr), .rd_o (dec_rd), .rs_o (dec_rs), .rt_o (dec_rt),
		.aluop_o (dec_aluop), .imm_o (dec_imm), .use_imm_o (dec_use_imm),
		.regwrite_o (dec_regwrite), .memread_o (dec_memread), .memwrite_o (dec_memwrite)
	);

	// Port 3 reads the store data register
	cpu16_regfile u_regfile (
		.clk_i (clk_i), .rst_n_i (rst_n_i),
		.ra1_i (dec_rs), .ra2_i (dec_rt), .ra3_i (dec_rd),
		.wa_i (memwb_rd), .we_i (wb_we), .wd_i (memwb_data),
		.rd1_o (rf_rd1), .rd2_o (rf_rd2), .rd3_o (rf_rd3)
	);

	// Pipeline payload registers
	always_ff @(posedge clk_i) begin
		ifid_instr <= instr_i;
		// ID/EX
		idex_rd          <= dec_rd;
		idex_regwrite    <= dec_regwrite;
		idex_memread     <= dec_memread;
		idex_memwrite    <= dec_memwrite;
		ex_bus.aluop     <= dec_aluop;
		ex_bus.alusrc1   <= rf_rd1;
		ex_bus.alusrc2   <= dec_use_imm ? dec_imm : rf_rd2;
		ex_bus.regsrc1   <= dec_rs;
		ex_bus.regsrc2   <= dec_rt;
		ex_bus.regsrc_sw <= dec_memwrite ? dec_rd : `CPU16_NO_REG;
		ex_bus.memdata   <= rf_rd3;
		// EX/MEM
		exmem_rd       <= idex_rd;
		exmem_regwrite <= idex_regwrite;
		exmem_memread  <= idex_memread;
		exmem_memwrite <= idex_memwrite;
		exmem_alures   <= ex_alures;
		exmem_stdata   <= ex_stdata;
		// MEM/WB
		memwb_rd       <= exmem_rd;
		memwb_regwrite <= exmem_regwrite;
		memwb_data     <= mem_result;
	end

	//////////////////////////////
	// EX and MEM
	//////////////////////////////

	assign ex_fwd_we = exmem_valid & exmem_regwrite;

	cpu16_ex u_ex (
		.ex_if (ex_bus.stage_dst),
		.exregdst_i (exmem_rd), .exregwrite_i (ex_fwd_we), .exregdata_i (exmem_alures),
		.memregdst_i (memwb_rd), .memregwrite_i (wb_we), .memregdata_i (memwb_data),
		.alures_o (ex_alures), .memdata_o (ex_stdata)
	);

	// Word address is the low bits of the sum
	cpu16_mem_stage u_mem (
		.clk_i (clk_i), .rst_n_i (rst_n_i),
		.we_i (st_en_o), .memread_i (exmem_memread),
		.addr_i (exmem_alures[`CPU16_DMEM_AW-1:0]), .wdata_i (exmem_stdata),
		.alures_i (exmem_alures), .result_o (mem_result)
	);

	// External strobes
	assign st_en_o   = exmem_valid & exmem_memwrite;
	assign st_addr_o = exmem_alures[`CPU16_DMEM_AW-1:0];
	assign st_data_o = exmem_stdata;
	assign wb_we     = memwb_valid & memwb_regwrite;
	assign wb_en_o   = wb_we;
	assign wb_dst_o  = memwb_rd;
	assign wb_data_o = memwb_data;

endmodule

`default_nettype wire

/* dv/cpu16_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu16_consts.svh"

module cpu16_chk (
	input logic                 clk_i,
	input logic                 rst_n_i,
	input logic                 wb_en_i,
	input cpu16_pkg::reg_addr_t wb_dst_i,
	input logic                 st_en_i
);

	// Read by the testbench at the end of the run
	int assert_fails = 0;

	//////////////////////////////
	// Pipeline control
	//////////////////////////////

	// Valid chain is cleared, so no strobe while reset is held
	reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> (!wb_en_i && !st_en_i))
		else begin
			assert_fails++;
			$error("writeback or store strobe high during reset");
		end

	// Decode drops every write to code 15
	no_wb_r15: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_en_i |-> (wb_dst_i != `CPU16_NO_REG))
		else begin
			assert_fails++;
			$error("writeback to register code 15");
		end

	// A store moves on to MEM/WB, where it writes nothing back
	store_no_wb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		st_en_i |=> !wb_en_i)
		else begin
			assert_fails++;
			$error("store instruction produced a writeback");
		end

endmodule

`default_nettype wire

/* dv/cpu16_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu16_consts.svh"

module cpu16_tb;

	localparam int NUM_INSTR = 400;

	logic clk;
	logic rst_n;
	logic instr_valid;
	cpu16_pkg::instr_t instr;
	logic wb_en;
	cpu16_pkg::reg_addr_t wb_dst;
	cpu16_pkg::word_t wb_data;
	logic st_en;
	cpu16_pkg::dmem_addr_t st_addr;
	cpu16_pkg::word_t st_data;

	// Rising edges seen so far
	// Updated just after each edge
	int edge_cnt = 0;
	int errors;
	int wb_checked;
	int st_checked;
	logic gen_done;
	logic [31:0] lfsr;

	// Program slots
	// A low valid bit is a bubble
	cpu16_pkg::instr_t prog_instr[$];
	logic prog_valid[$];

	// Reference model state
	// r15 stays zero
	cpu16_pkg::word_t mregs [16];
	cpu16_pkg::word_t mmem [`CPU16_DMEM_DEPTH];

	// Expected strobes with the edge count they show up at
	int wb_edge_q[$];
	cpu16_pkg::reg_addr_t wb_dst_q[$];
	cpu16_pkg::word_t wb_data_q[$];
	int st_edge_q[$];
	cpu16_pkg::dmem_addr_t st_addr_q[$];
	cpu16_pkg::word_t st_data_q[$];

	cpu16_core cpu16_core_i (
		.clk_i (clk), .rst_n_i (rst_n), .instr_valid_i (instr_valid), .instr_i (instr),
		.wb_en_o (wb_en), .wb_dst_o (wb_dst), .wb_data_o (wb_data),
		.st_en_o (st_en), .st_addr_o (st_addr), .st_data_o (st_data)
	);

	bind cpu16_core cpu16_chk u_chk (
		.clk_i (clk_i), .rst_n_i (rst_n_i), .wb_en_i (wb_en_o),
		.wb_dst_i (wb_dst_o), .st_en_i (st_en_o)
	);

	always #5 clk = ~clk;

	always @(posedge clk) edge_cnt <= edge_cnt + 1;

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	// Fibonacci LFSR with taps 32 22 2 1
	// One step per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[14:0], fb};
		end
		return v;
	endfunction

	// Mostly r0 to r3 so that dependencies are frequent
	function automatic cpu16_pkg::reg_addr_t pick_reg();
		logic [2:0] r;
		r = 3'(rand_bits(3));
		if (r < 3'd6)
			return {2'b00, r[1:0]};
		else if (r == 3'd6)
			return `CPU16_NO_REG;
		return 4'(rand_bits(4));
	endfunction

	task automatic gen_program();
		cpu16_pkg::alu_op_t op;
		cpu16_pkg::reg_addr_t rd, rs, rt;
		cpu16_pkg::reg_addr_t ld_rd;
		logic [3:0] r;
		logic ld_pending;
		ld_pending = 1'b0;
		ld_rd = '0;
		for (int n = 0; n < NUM_INSTR; n++) begin
			// Bubble with junk on the instruction bus
			if (rand_bits(3) == 16'd0) begin
				prog_instr.push_back(rand_bits(16));
				prog_valid.push_back(1'b0);
				ld_pending = 1'b0;
				continue;
			end
			r = 4'(rand_bits(4));
			if (r >= 4'd13)
				op = r;
			else if (r >= 4'd10)
				op = r[0] ? `CPU16_OP_LW : `CPU16_OP_SW;
			else
				op = r;
			rd = pick_reg();
			rs = pick_reg();
			rt = (op >= `CPU16_OP_ADDI) ? 4'(rand_bits(4)) : pick_reg();
			// Base of zero reuses low addresses so loads hit stores
			if ((op == `CPU16_OP_LW || op == `CPU16_OP_SW) && rand_bits(1) == 16'd1)
				rs = `CPU16_NO_REG;
			// Load-use at distance 1 gets a NOP in between
			if (ld_pending && (rs == ld_rd || rt == ld_rd ||
					(op == `CPU16_OP_SW && rd == ld_rd))) begin
				prog_instr.push_back(16'hF000);
				prog_valid.push_back(1'b1);
			end
			prog_instr.push_back({op, rd, rs, rt});
			prog_valid.push_back(1'b1);
			ld_pending = (op == `CPU16_OP_LW) && (rd != `CPU16_NO_REG);
			ld_rd = rd;
		end
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Sequential execution
	// d is the edge the slot is driven on
	task automatic model_exec(input cpu16_pkg::instr_t ins, input int d);
		cpu16_pkg::alu_op_t op;
		cpu16_pkg::reg_addr_t rd;
		cpu16_pkg::word_t a, b, imm, ea, res;
		cpu16_pkg::dmem_addr_t addr;
		logic wr;
		op = ins[15:12];
		rd = ins[11:8];
		a = mregs[ins[7:4]];
		b = mregs[ins[3:0]];
		imm = {12'h000, ins[3:0]};
		ea = a + imm;
		addr = ea[`CPU16_DMEM_AW-1:0];
		wr = 1'b1;
		res = '0;
		case (op)
			`CPU16_OP_ADD: res = a + b;
			`CPU16_OP_SUB: res = a - b;
			`CPU16_OP_AND: res = a & b;
			`CPU16_OP_OR: res = a | b;
			`CPU16_OP_XOR: res = a ^ b;
			`CPU16_OP_SLL: res = a << b[3:0];
			`CPU16_OP_SRL: res = a >> b[3:0];
			`CPU16_OP_ADDI: res = ea;
			`CPU16_OP_LW: res = mmem[addr];
			`CPU16_OP_SW: begin
				wr = 1'b0;
				mmem[addr] = mregs[rd];
				st_edge_q.push_back(d + 3);
				st_addr_q.push_back(addr);
				st_data_q.push_back(mregs[rd]);
			end
			default: wr = 1'b0;
		endcase
		if (wr && rd != `CPU16_NO_REG) begin
			mregs[rd] = res;
			wb_edge_q.push_back(d + 4);
			wb_dst_q.push_back(rd);
			wb_data_q.push_back(res);
		end
	endtask

	//////////////////////////////
	// Output checks
	//////////////////////////////

	task automatic flag_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
		errors++;
		$display("CHECK FAILED %s: expected 0x%0h actual 0x%0h", name, exp, act);
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin : wb_monitor
		int exp_edge;
		cpu16_pkg::reg_addr_t exp_dst;
		cpu16_pkg::word_t exp_data;
		if (wb_en) begin
			if (wb_edge_q.size() == 0) begin
				errors++;
				$display("ERROR: writeback to r%0d at edge %0d with none pending", wb_dst, edge_cnt);
			end else begin
				exp_edge = wb_edge_q.pop_front();
				exp_dst = wb_dst_q.pop_front();
				exp_data = wb_data_q.pop_front();
				wb_checked++;
				if (edge_cnt != exp_edge)
					flag_mismatch("wb_cycle", exp_edge, edge_cnt);
				if (wb_dst != exp_dst)
					flag_mismatch("wb_dst", exp_dst, wb_dst);
				if (wb_data != exp_data)
					flag_mismatch("wb_data", exp_data, wb_data);
			end
		end else if (wb_edge_q.size() > 0 && wb_edge_q[0] == edge_cnt) begin
			errors++;
			$display("ERROR: writeback to r%0d expected at edge %0d did not happen",
				wb_dst_q[0], edge_cnt);
			void'(wb_edge_q.pop_front());
			void'(wb_dst_q.pop_front());
			void'(wb_data_q.pop_front());
		end
	end

	always @(negedge clk) begin : st_monitor
		int exp_edge;
		cpu16_pkg::dmem_addr_t exp_addr;
		cpu16_pkg::word_t exp_data;
		if (st_en) begin
			if (st_edge_q.size() == 0) begin
				errors++;
				$display("ERROR: store to 0x%0h at edge %0d with none pending", st_addr, edge_cnt);
			end else begin
				exp_edge = st_edge_q.pop_front();
				exp_addr = st_addr_q.pop_front();
				exp_data = st_data_q.pop_front();
				st_checked++;
				if (edge_cnt != exp_edge)
					flag_mismatch("st_cycle", exp_edge, edge_cnt);
				if (st_addr != exp_addr)
					flag_mismatch("st_addr", exp_addr, st_addr);
				if (st_data != exp_data)
					flag_mismatch("st_data", exp_data, st_data);
			end
		end else if (st_edge_q.size() > 0 && st_edge_q[0] == edge_cnt) begin
			errors++;
			$display("ERROR: store to 0x%0h expected at edge %0d did not happen",
				st_addr_q[0], edge_cnt);
			void'(st_edge_q.pop_front());
			void'(st_addr_q.pop_front());
			void'(st_data_q.pop_front());
		end
	end

	// Whole program plus reset and pipeline drain
	initial begin : watchdog
		wait (gen_done);
		#((prog_instr.size() + 20) * 10);
		$display("ERROR: timeout, the run did not complete in time");
		$display("RESULT: FAIL");
		$finish;
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		errors = 0;
		wb_checked = 0;
		st_checked = 0;
		gen_done = 1'b0;
		lfsr = 32'he17a;
		for (int i = 0; i < 16; i++)
			mregs[i] = '0;
		for (int i = 0; i < `CPU16_DMEM_DEPTH; i++)
			mmem[i] = '0;
		gen_program();
		gen_done = 1'b1;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		for (int s = 0; s < prog_instr.size(); s++) begin
			@(posedge clk);
			instr_valid <= prog_valid[s];
			instr <= prog_instr[s];
			if (prog_valid[s])
				model_exec(prog_instr[s], edge_cnt + 1);
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		instr <= '0;
		// Drain the pipeline
		repeat (8) @(posedge clk);
		$display("Checks failed: %0d, assertion failures: %0d, writebacks: %0d, stores: %0d",
			errors, cpu16_core_i.u_chk.assert_fails, wb_checked, st_checked);
		if (errors == 0 && cpu16_core_i.u_chk.assert_fails == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
logic/cpu16_pkg.sv
logic/cpu16_ex_if.sv
logic/cpu16_decode.sv
logic/cpu16_regfile.sv
logic/cpu16_alu.sv
logic/cpu16_ex.sv
logic/cpu16_mem_stage.sv
logic/cpu16_core.sv
dv/cpu16_chk.sv
dv/cpu16_tb.sv
